/* logic/rom_downloader.sv */
/*
 * ROM loader path into the SDRAM.
 * Pairs loader bytes into 16-bit words, even byte low,
 * and writes each word through the program port.
 */
`timescale 1ns/1ps

module rom_downloader (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      downloading,
    input  logic [25:0]               ioctl_addr,
    input  logic [7:0]                ioctl_dout,
    input  logic                      ioctl_wr,
    output snowbro2_pkg::sdram_addr_t prog_addr,
    output snowbro2_pkg::sdram_word_t prog_data,
    output logic [1:0]                prog_mask,
    output logic                      prog_we,
    input  logic                      prog_rdy,
    output logic                      dwnld_busy
);
    import snowbro2_pkg::*;

    logic [7:0] low_byte;
    logic       wr_even;
    logic       wr_odd;

    assign wr_even = downloading && ioctl_wr && !ioctl_addr[0];
    assign wr_odd  = downloading && ioctl_wr && ioctl_addr[0];

    // both bytes always written
    assign prog_mask  = 2'b00;
    assign dwnld_busy = downloading || prog_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (wr_odd) begin
            prog_we <= 1'b1;
        end else if (prog_rdy) begin
            prog_we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_even) begin
            low_byte <= ioctl_dout;
        end
        if (wr_odd) begin
            // byte address to word address
            prog_addr <= sdram_addr_t'(ioctl_addr >> 1);
            prog_data <= {ioctl_dout, low_byte};
        end
    end

endmodule

/* logic/rom_req_if.sv */
/*
 * Request path between one ROM slot and the bank arbiter.
 * Slot side drives req/addr, arbiter side returns ack/data.
 */
`timescale 1ns/1ps

interface rom_req_if;
    import snowbro2_pkg::*;

    logic        req;
    sdram_addr_t addr;
    // one pulse per delivered word
    logic        ack;
    sdram_word_t data;

    modport slot (
        output req,
        output addr,
        input  ack,
        input  data
    );

    modport arbiter (
        input  req,
        input  addr,
        output ack,
        output data
    );

endinterface

/* logic/rom_slot.sv */
/*
 * ROM slot for one client of the SDRAM bank.
 * Holds a one-entry cache of the last address and payload,
 * fetches a miss one SDRAM word at a time through the arbiter,
 * and splits bytes out of words for 8-bit payloads.
 */
`timescale 1ns/1ps

module rom_slot #(
    parameter type                       data_t = snowbro2_pkg::sdram_word_t,
    parameter snowbro2_pkg::sdram_addr_t BASE   = '0,
    parameter int                        AW     = 16
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic          ok,
    output data_t         dout,
    rom_req_if.slot       mem
);
    import snowbro2_pkg::*;

    localparam int DW     = $bits(data_t);
    localparam bit NARROW = DW < 16;
    localparam int WORDS  = NARROW ? 1 : DW / 16;
    localparam int CW     = WORDS > 1 ? $clog2(WORDS) : 1;

    logic                cache_valid;
    logic [AW-1:0]       cache_addr;
    logic [WORDS*16-1:0] line;
    logic [CW-1:0]       word_cnt;
    logic                hit;
    logic                start;
    logic                last_word;
    sdram_addr_t         first_word;

    assign hit       = cs && cache_valid && addr == cache_addr;
    // req doubles as the busy flag
    assign start     = cs && !hit && !mem.req;
    assign last_word = word_cnt == CW'(WORDS - 1);

    // first SDRAM word of the payload at addr
    always_comb begin
        if (NARROW) begin
            first_word = BASE + sdram_addr_t'(addr >> 1);
        end else begin
            first_word = BASE + sdram_addr_t'(addr) * sdram_addr_t'(WORDS);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cache_valid <= 1'b0;
            ok          <= 1'b0;
            mem.req     <= 1'b0;
            word_cnt    <= '0;
        end else begin
            ok <= hit;
            if (start) begin
                cache_valid <= 1'b0;
                mem.req     <= 1'b1;
                word_cnt    <= '0;
            end else if (mem.req && mem.ack) begin
                if (last_word) begin
                    mem.req     <= 1'b0;
                    cache_valid <= 1'b1;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // words land low word first
    always_ff @(posedge clk) begin
        if (start) begin
            cache_addr <= addr;
            mem.addr   <= first_word;
        end else if (mem.req && mem.ack) begin
            line[word_cnt*16 +: 16] <= mem.data;
            mem.addr                <= mem.addr + 1'b1;
        end
    end

    generate
        if (NARROW) begin : g_byte
            // odd address takes the high byte
            assign dout = data_t'(cache_addr[0] ? line[2*DW-1:DW] : line[DW-1:0]);
        end else begin : g_word
            assign dout = data_t'(line);
        end
    endgenerate

endmodule

/* logic/sdram_arbiter.sv */
/*
 * Fixed-priority arbiter for the bank 0 read port.
 * Program slot first, then graphics, then samples.
 * A grant is held until its slot drops req, and no
 * grant is given while the loader owns the bank.
 */
`timescale 1ns/1ps

module sdram_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      downloading,
    rom_req_if.arbiter                prg,
    rom_req_if.arbiter                gfx,
    rom_req_if.arbiter                pcm,
    output snowbro2_pkg::sdram_addr_t ba0_addr,
    output logic                      ba_rd,
    input  logic                      ba_ack,
    input  logic                      ba_dok,
    input  logic                      ba_rdy,
    input  snowbro2_pkg::sdram_word_t data_read
);
    import snowbro2_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT} state_t;
    typedef enum logic [1:0] {GNT_NONE, GNT_PRG, GNT_GFX, GNT_PCM} grant_t;

    state_t      state;
    grant_t      gnt;
    grant_t      next_gnt;
    logic        cur_req;
    logic        issue;
    logic        beat;
    sdram_addr_t next_addr;

    always_comb begin
        case (gnt)
            GNT_PRG: cur_req = prg.req;
            GNT_GFX: cur_req = gfx.req;
            GNT_PCM: cur_req = pcm.req;
            default: cur_req = 1'b0;
        endcase
    end

    // sticky grant, otherwise priority order
    always_comb begin
        if (cur_req)       next_gnt = gnt;
        else if (prg.req)  next_gnt = GNT_PRG;
        else if (gfx.req)  next_gnt = GNT_GFX;
        else if (pcm.req)  next_gnt = GNT_PCM;
        else               next_gnt = GNT_NONE;
    end

    always_comb begin
        case (next_gnt)
            GNT_GFX: next_addr = gfx.addr;
            GNT_PCM: next_addr = pcm.addr;
            default: next_addr = prg.addr;
        endcase
    end

    assign issue = state == ST_IDLE && !downloading && next_gnt != GNT_NONE;
    assign beat  = state == ST_WAIT && ba_dok && ba_rdy;

    // data beat goes straight back to the owner
    assign prg.ack  = beat && gnt == GNT_PRG;
    assign gfx.ack  = beat && gnt == GNT_GFX;
    assign pcm.ack  = beat && gnt == GNT_PCM;
    assign prg.data = data_read;
    assign gfx.data = data_read;
    assign pcm.data = data_read;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            gnt   <= GNT_NONE;
            ba_rd <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!downloading) begin
                        gnt <= next_gnt;
                    end
                    if (issue) begin
                        ba_rd <= 1'b1;
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (beat) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ba0_addr <= next_addr;
        end
    end

endmodule

/* logic/snowbro2_clock.sv */
/*
 * Pixel clock enables from the 48 MHz clock.
 * Fractional accumulators give 6.75 MHz and 13.5 MHz strobes,
 * each a single-cycle pulse.
 */
`timescale 1ns/1ps

module snowbro2_clock (
    input  logic clk,
    input  logic rst_n,
    output logic pxl_cen,
    output logic pxl2_cen
);

    // 48 MHz * 9/64 = 6.75 MHz, 48 MHz * 18/64 = 13.5 MHz
    localparam logic [6:0] PXL_STEP  = 7'd9;
    localparam logic [6:0] PXL2_STEP = 7'd18;

    logic [5:0] pxl_acc;
    logic [5:0] pxl2_acc;
    logic [6:0] pxl_sum;
    logic [6:0] pxl2_sum;

    // bit 6 is the wrap out of the phase
    assign pxl_sum  = {1'b0, pxl_acc} + PXL_STEP;
    assign pxl2_sum = {1'b0, pxl2_acc} + PXL2_STEP;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl_acc  <= '0;
            pxl2_acc <= '0;
            pxl_cen  <= 1'b0;
            pxl2_cen <= 1'b0;
        end else begin
            pxl_acc  <= pxl_sum[5:0];
            pxl2_acc <= pxl2_sum[5:0];
            // strobe on every wrap
            pxl_cen  <= pxl_sum[6];
            pxl2_cen <= pxl2_sum[6];
        end
    end

endmodule

/* logic/snowbro2_config.svh */
/*
 * Address widths of the SDRAM bank and of the three ROM clients,
 * and the base word address of each ROM region in bank 0.
 */
`ifndef SNOWBRO2_CONFIG_SVH
`define SNOWBRO2_CONFIG_SVH

// SDRAM word address width
`define SNOWBRO2_SDRAM_AW 22

// client address widths, in each client's own units
`define SNOWBRO2_PRG_AW 19
`define SNOWBRO2_GFX_AW 22
`define SNOWBRO2_PCM_AW 20

// region bases, in 16-bit SDRAM words
`define SNOWBRO2_PRG_BASE 22'h000000
`define SNOWBRO2_GFX_BASE 22'h080000
`define SNOWBRO2_PCM_BASE 22'h280000

`endif

/* logic/snowbro2_game.sv */
/*
 * Memory side of the game top level.
 * Pixel clock enables, three ROM slots sharing SDRAM bank 0
 * through a fixed-priority arbiter, and the ROM loader.
 */
`timescale 1ns/1ps
`include "snowbro2_config.svh"

module snowbro2_game (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        pxl_cen,
    output logic                        pxl2_cen,
    // 68000 program ROM
    input  logic                        prg_cs,
    input  logic [`SNOWBRO2_PRG_AW-1:0] prg_addr,
    output logic                        prg_ok,
    output snowbro2_pkg::prg_data_t     prg_dout,
    // tile graphics ROM
    input  logic                        gfx_cs,
    input  logic [`SNOWBRO2_GFX_AW-1:0] gfx_addr,
    output logic                        gfx_ok,
    output snowbro2_pkg::gfx_data_t     gfx_dout,
    // ADPCM sample ROM
    input  logic                        pcm_cs,
    input  logic [`SNOWBRO2_PCM_AW-1:0] pcm_addr,
    output logic                        pcm_ok,
    output snowbro2_pkg::pcm_data_t     pcm_dout,
    // SDRAM bank 0
    output snowbro2_pkg::sdram_addr_t   ba0_addr,
    output logic                        ba_rd,
    input  logic                        ba_ack,
    input  logic                        ba_dok,
    input  logic                        ba_rdy,
    input  snowbro2_pkg::sdram_word_t   data_read,
    // ROM loader
    input  logic                        downloading,
    output logic                        dwnld_busy,
    input  logic [25:0]                 ioctl_addr,
    input  logic [7:0]                  ioctl_dout,
    input  logic                        ioctl_wr,
    output snowbro2_pkg::sdram_addr_t   prog_addr,
    output snowbro2_pkg::sdram_word_t   prog_data,
    output logic [1:0]                  prog_mask,
    output logic                        prog_we,
    input  logic                        prog_rdy
);
    import snowbro2_pkg::*;

    rom_req_if prg_req ();
    rom_req_if gfx_req ();
    rom_req_if pcm_req ();

    snowbro2_clock u_clocken (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen)
    );

    rom_slot #(
        .data_t (prg_data_t),
        .BASE   (`SNOWBRO2_PRG_BASE),
        .AW     (`SNOWBRO2_PRG_AW)
    ) u_prg_slot (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (prg_cs),
        .addr  (prg_addr),
        .ok    (prg_ok),
        .dout  (prg_dout),
        .mem   (prg_req.slot)
    );

    // two words per tile fetch
    rom_slot #(
        .data_t (gfx_data_t),
        .BASE   (`SNOWBRO2_GFX_BASE),
        .AW     (`SNOWBRO2_GFX_AW)
    ) u_gfx_slot (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (gfx_cs),
        .addr  (gfx_addr),
        .ok    (gfx_ok),
        .dout  (gfx_dout),
        .mem   (gfx_req.slot)
    );

    rom_slot #(
        .data_t (pcm_data_t),
        .BASE   (`SNOWBRO2_PCM_BASE),
        .AW     (`SNOWBRO2_PCM_AW)
    ) u_pcm_slot (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (pcm_cs),
        .addr  (pcm_addr),
        .ok    (pcm_ok),
        .dout  (pcm_dout),
        .mem   (pcm_req.slot)
    );

    sdram_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .prg         (prg_req.arbiter),
        .gfx         (gfx_req.arbiter),
        .pcm         (pcm_req.arbiter),
        .ba0_addr    (ba0_addr),
        .ba_rd       (ba_rd),
        .ba_ack      (ba_ack),
        .ba_dok      (ba_dok),
        .ba_rdy      (ba_rdy),
        .data_read   (data_read)
    );

    rom_downloader u_downloader (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prog_rdy    (prog_rdy),
        .dwnld_busy  (dwnld_busy)
    );

endmodule

/* logic/snowbro2_pkg.sv */
/*
 * Shared types of the memory side.
 * SDRAM word and word address, and the payload type
 * of each ROM client.
 */
`include "snowbro2_config.svh"

package snowbro2_pkg;

    // one word of the SDRAM bank
    typedef logic [15:0] sdram_word_t;

    // word address into bank 0
    typedef logic [`SNOWBRO2_SDRAM_AW-1:0] sdram_addr_t;

    // 68000 program ROM, one word per access
    typedef logic [15:0] prg_data_t;

    // tile graphics ROM, two SDRAM words per access
    typedef logic [31:0] gfx_data_t;

    // ADPCM sample ROM, one byte per access
    typedef logic [7:0] pcm_data_t;

endpackage

/* project.f */
+incdir+logic
logic/snowbro2_pkg.sv
logic/rom_req_if.sv
logic/snowbro2_clock.sv
logic/rom_slot.sv
logic/sdram_arbiter.sv
logic/rom_downloader.sv
logic/snowbro2_game.sv
verif/snowbro2_checker.sv
verif/snowbro2_tb.sv

/* verif/snowbro2_checker.sv */
/*
 * Concurrent assertions on the bank 0 read handshake
 * and on the program write handshake, with the bind
 * statements that attach them to the arbiter and the loader.
 */
`timescale 1ns/1ps

module snowbro2_checker (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      downloading,
    input logic                      rd,
    input logic                      ack,
    input snowbro2_pkg::sdram_addr_t rd_addr,
    input logic                      we,
    input logic                      rdy,
    input snowbro2_pkg::sdram_addr_t wr_addr,
    input snowbro2_pkg::sdram_word_t wr_data
);

    // set by any failed assertion, watched by the testbench
    logic failed = 1'b0;

    // address held for the whole read request
    property rd_addr_held;
        @(posedge clk) disable iff (!rst_n)
        rd && !ack |=> rd && $stable(rd_addr);
    endproperty

    // no read starts while the loader owns the bank
    property no_rd_in_download;
        @(posedge clk) disable iff (!rst_n)
        $rose(rd) |-> !$past(downloading);
    endproperty

    // write strobe and word held until rdy
    property prog_write_held;
        @(posedge clk) disable iff (!rst_n)
        we && !rdy |=> we && $stable(wr_data) && $stable(wr_addr);
    endproperty

    a_rd_addr_held: assert property (rd_addr_held)
        else begin
            $error("ba0_addr or ba_rd changed before ba_ack");
            failed = 1'b1;
        end
    a_no_rd_in_download: assert property (no_rd_in_download)
        else begin
            $error("ba_rd raised while downloading");
            failed = 1'b1;
        end
    a_prog_write_held: assert property (prog_write_held)
        else begin
            $error("prog_we or prog_data dropped before prog_rdy");
            failed = 1'b1;
        end

endmodule

bind sdram_arbiter snowbro2_checker u_bank_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .downloading (downloading),
    .rd          (ba_rd),
    .ack         (ba_ack),
    .rd_addr     (ba0_addr),
    .we          (1'b0),
    .rdy         (1'b0),
    .wr_addr     ('0),
    .wr_data     ('0)
);

bind rom_downloader snowbro2_checker u_prog_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .downloading (downloading),
    .rd          (1'b0),
    .ack         (1'b0),
    .rd_addr     ('0),
    .we          (prog_we),
    .rdy         (prog_rdy),
    .wr_addr     (prog_addr),
    .wr_data     (prog_data)
);

/* verif/snowbro2_tb.sv */
/*
 * Testbench for the game memory side.
 * SDRAM bank and program port models, random ROM clients,
 * a reference model of the three ROM regions, compare tasks
 * and a watchdog.
 */
`timescale 1ns/1ps
`include "snowbro2_config.svh"

module snowbro2_tb;
    import snowbro2_pkg::*;

    localparam int CLK_TEST = 640;
    localparam int N_LOAD   = 64;
    localparam int N_PRG    = 200;
    localparam int N_GFX    = 40;
    localparam int N_PCM    = 40;
    localparam int N_CONT   = 20;
    localparam int N_TRANS  = N_LOAD + N_PRG + N_GFX + N_PCM + 3 * N_CONT + 7;
    // loaded bytes land at program words 0x80 to 0x9f
    localparam logic [25:0] LOAD_BYTE = 26'h000100;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        pxl_cen;
    logic                        pxl2_cen;
    logic                        prg_cs;
    logic [`SNOWBRO2_PRG_AW-1:0] prg_addr;
    logic                        prg_ok;
    prg_data_t                   prg_dout;
    logic                        gfx_cs;
    logic [`SNOWBRO2_GFX_AW-1:0] gfx_addr;
    logic                        gfx_ok;
    gfx_data_t                   gfx_dout;
    logic                        pcm_cs;
    logic [`SNOWBRO2_PCM_AW-1:0] pcm_addr;
    logic                        pcm_ok;
    pcm_data_t                   pcm_dout;
    sdram_addr_t                 ba0_addr;
    logic                        ba_rd;
    logic                        ba_ack = 1'b0;
    logic                        ba_dok = 1'b0;
    logic                        ba_rdy = 1'b0;
    sdram_word_t                 data_read = '0;
    logic                        downloading;
    logic                        dwnld_busy;
    logic [25:0]                 ioctl_addr;
    logic [7:0]                  ioctl_dout;
    logic                        ioctl_wr;
    sdram_addr_t                 prog_addr;
    sdram_word_t                 prog_data;
    logic [1:0]                  prog_mask;
    logic                        prog_we;
    logic                        prog_rdy = 1'b0;

    logic [31:0] rng_state = 32'hdeb3_df3f;
    // words written through the program port, as the bank holds them
    sdram_word_t sdram_mem [sdram_addr_t];
    // words the loader was given, as the reference sees them
    sdram_word_t ref_mem [sdram_addr_t];
    sdram_addr_t exp_addr_q [$];
    sdram_word_t exp_data_q [$];
    int          rd_count = 0;
    int          wr_count = 0;

    snowbro2_game i_snowbro2_game (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // contents of a word never written by the loader
    function automatic sdram_word_t hash_word(input sdram_addr_t a);
        logic [31:0] h;
        h = {10'd0, a} * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        return h[15:0];
    endfunction

    function automatic sdram_word_t ref_word(input sdram_addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return hash_word(a);
    endfunction

    function automatic prg_data_t expect_prg(input logic [`SNOWBRO2_PRG_AW-1:0] a);
        return ref_word(`SNOWBRO2_PRG_BASE + sdram_addr_t'(a));
    endfunction

    // two words, low word first
    function automatic gfx_data_t expect_gfx(input logic [`SNOWBRO2_GFX_AW-1:0] a);
        sdram_addr_t w;
        w = `SNOWBRO2_GFX_BASE + sdram_addr_t'(a) * 2;
        return {ref_word(w + 1'b1), ref_word(w)};
    endfunction

    function automatic pcm_data_t expect_pcm(input logic [`SNOWBRO2_PCM_AW-1:0] a);
        sdram_word_t word;
        word = ref_word(`SNOWBRO2_PCM_BASE + sdram_addr_t'(a >> 1));
        return a[0] ? word[15:8] : word[7:0];
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_prg(input string name, input prg_data_t exp, input prg_data_t act);
        if (exp !== act)
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_gfx(input string name, input gfx_data_t exp, input gfx_data_t act);
        if (exp !== act)
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_pcm(input string name, input pcm_data_t exp, input pcm_data_t act);
        if (exp !== act)
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input sdram_word_t exp,
                              input sdram_word_t act);
        if (exp !== act)
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input sdram_addr_t exp,
                              input sdram_addr_t act);
        if (exp !== act)
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp !== act)
            fail_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
    endtask

    // client reads, called 1 ns after a rising edge
    task automatic read_prg(input string name, input logic [`SNOWBRO2_PRG_AW-1:0] a,
                            output int cycles);
        prg_cs   = 1'b1;
        prg_addr = a;
        cycles   = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!prg_ok);
        check_prg(name, expect_prg(a), prg_dout);
        prg_cs = 1'b0;
    endtask

    task automatic read_gfx(input string name, input logic [`SNOWBRO2_GFX_AW-1:0] a,
                            output int cycles);
        gfx_cs   = 1'b1;
        gfx_addr = a;
        cycles   = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!gfx_ok);
        check_gfx(name, expect_gfx(a), gfx_dout);
        gfx_cs = 1'b0;
    endtask

    task automatic read_pcm(input string name, input logic [`SNOWBRO2_PCM_AW-1:0] a,
                            output int cycles);
        pcm_cs   = 1'b1;
        pcm_addr = a;
        cycles   = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!pcm_ok);
        check_pcm(name, expect_pcm(a), pcm_dout);
        pcm_cs = 1'b0;
    endtask

    // one byte per cycle, waiting out each word write
    task automatic load_bytes();
        logic [31:0] r;
        logic [7:0]  even_b;
        logic [25:0] a;
        downloading = 1'b1;
        for (int i = 0; i < N_LOAD; i++) begin
            r          = xorshift32();
            a          = LOAD_BYTE + 26'(i);
            ioctl_addr = a;
            ioctl_dout = r[7:0];
            ioctl_wr   = 1'b1;
            // expected word queued before the edge that raises prog_we
            if (a[0]) begin
                exp_addr_q.push_back(sdram_addr_t'(a >> 1));
                exp_data_q.push_back({r[7:0], even_b});
                ref_mem[sdram_addr_t'(a >> 1)] = {r[7:0], even_b};
            end else begin
                even_b = r[7:0];
            end
            @(posedge clk);
            #1;
            ioctl_wr = 1'b0;
            while (prog_we) begin
                @(posedge clk);
                #1;
            end
        end
        downloading = 1'b0;
        @(posedge clk);
        #1;
        if (dwnld_busy)
            fail_run("dwnld_busy still high after the last loader write");
        check_count("loader write count", N_LOAD / 2, wr_count);
    endtask

    // bank 0: ack after 0 to 5 cycles, data beat 1 to 3 cycles later
    always begin : sdram_model
        int          n;
        sdram_addr_t a;
        @(posedge clk);
        #1;
        if (ba_rd) begin
            rd_count++;
            a = ba0_addr;
            n = int'(xorshift32() % 6);
            repeat (n) begin
                @(posedge clk);
                #1;
            end
            ba_ack = 1'b1;
            @(posedge clk);
            #1;
            ba_ack = 1'b0;
            n = 1 + int'(xorshift32() % 3);
            repeat (n - 1) begin
                @(posedge clk);
                #1;
            end
            ba_dok    = 1'b1;
            ba_rdy    = 1'b1;
            data_read = sdram_mem.exists(a) ? sdram_mem[a] : hash_word(a);
            @(posedge clk);
            #1;
            ba_dok = 1'b0;
            ba_rdy = 1'b0;
        end
    end

    // program port: rdy after 1 to 4 cycles
    always begin : prog_model
        int n;
        @(posedge clk);
        #1;
        if (prog_we) begin
            n = 1 + int'(xorshift32() % 4);
            repeat (n - 1) begin
                @(posedge clk);
                #1;
            end
            if (exp_addr_q.size() == 0)
                fail_run("program write seen with no loader byte pair behind it");
            check_addr("loader address", exp_addr_q.pop_front(), prog_addr);
            check_word("loader data", exp_data_q.pop_front(), prog_data);
            check_count("loader mask", 0, int'(prog_mask));
            sdram_mem[prog_addr] = prog_data;
            wr_count++;
            prog_rdy = 1'b1;
            @(posedge clk);
            #1;
            prog_rdy = 1'b0;
        end
    end

    // a failed handshake assertion ends the run as well
    always @(posedge i_snowbro2_game.u_arbiter.u_bank_checker.failed or
             posedge i_snowbro2_game.u_downloader.u_prog_checker.failed) begin
        fail_run("a bound handshake assertion failed");
    end

    initial begin : watchdog
        repeat (N_TRANS * 200 + CLK_TEST + 10) @(posedge clk);
        fail_run("timeout: the run did not finish in the expected number of cycles");
    end

    initial begin : main
        logic [31:0]                 r;
        logic [`SNOWBRO2_PRG_AW-1:0] pa;
        logic [`SNOWBRO2_GFX_AW-1:0] ga;
        logic [`SNOWBRO2_PCM_AW-1:0] ca;
        int                          cyc_p;
        int                          cyc_g;
        int                          cyc_c;
        int                          pxl_count;
        int                          pxl2_count;
        int                          rd_before;
        rst_n       = 1'b0;
        prg_cs      = 1'b0;
        prg_addr    = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        pcm_cs      = 1'b0;
        pcm_addr    = '0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        pxl_count   = 0;
        pxl2_count  = 0;
        repeat (2) @(posedge clk);
        #1;
        if (ba_rd || prog_we || prg_ok || gfx_ok || pcm_ok || pxl_cen || pxl2_cen)
            fail_run("an output is not low during reset");
        rst_n = 1'b1;

        // pixel enables over ten 64-cycle periods
        repeat (CLK_TEST) begin
            @(posedge clk);
            #1;
            pxl_count  += int'(pxl_cen);
            pxl2_count += int'(pxl2_cen);
        end
        check_count("pxl_cen pulses", 90, pxl_count);
        check_count("pxl2_cen pulses", 180, pxl2_count);

        // graphics request held off by the download
        r  = xorshift32();
        ga = {2'b00, r[19:0]};
        fork
            load_bytes();
            read_gfx("gfx behind load", ga, cyc_g);
        join

        // every fourth read inside the loaded words
        for (int i = 0; i < N_PRG; i++) begin
            r  = xorshift32();
            pa = (i % 4 == 0) ? 19'h80 + 19'(r[4:0]) : r[18:0];
            read_prg("prg read", pa, cyc_p);
        end

        for (int i = 0; i < N_GFX; i++) begin
            r  = xorshift32();
            ga = {2'b00, r[19:0]};
            read_gfx("gfx read", ga, cyc_g);
        end

        for (int i = 0; i < N_PCM; i++) begin
            r  = xorshift32();
            ca = r[19:0];
            if (i % 2 == 1)
                ca[0] = 1'b1;
            read_pcm("pcm read", ca, cyc_c);
        end

        // all three clients at once
        for (int i = 0; i < N_CONT; i++) begin
            r  = xorshift32();
            pa = r[18:0];
            ga = {2'b00, r[31:12]};
            ca = r[25:6];
            fork
                read_prg("contention prg", pa, cyc_p);
                read_gfx("contention gfx", ga, cyc_g);
                read_pcm("contention pcm", ca, cyc_c);
            join
        end

        // same address again after one idle cycle
        r  = xorshift32();
        pa = r[18:0];
        ga = {2'b00, r[31:12]};
        ca = r[25:6];
        read_prg("prg fill", pa, cyc_p);
        @(posedge clk);
        #1;
        rd_before = rd_count;
        read_prg("prg hit", pa, cyc_p);
        check_count("prg hit latency", 1, cyc_p);
        check_count("prg hit bank reads", rd_before, rd_count);
        read_gfx("gfx fill", ga, cyc_g);
        @(posedge clk);
        #1;
        rd_before = rd_count;
        read_gfx("gfx hit", ga, cyc_g);
        check_count("gfx hit latency", 1, cyc_g);
        check_count("gfx hit bank reads", rd_before, rd_count);
        read_pcm("pcm fill", ca, cyc_c);
        @(posedge clk);
        #1;
        rd_before = rd_count;
        read_pcm("pcm hit", ca, cyc_c);
        check_count("pcm hit latency", 1, cyc_c);
        check_count("pcm hit bank reads", rd_before, rd_count);

        $display("Done: no errors");
        $finish;
    end

endmodule
